/* source/fb_consts.svh */
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// Framebuffer resolution in pixels
`define FB_X_RES 16
`define FB_Y_RES 8
`define FB_PIXELS 128

// Index into the pixel memory, log2 of FB_PIXELS
`define FB_ADDR_W 7

// Screen coordinates keep the renderer width
`define SCREEN_POS_W 11

// Internal channel width, the reduced color representation
`define SUB_PIXEL_W 6

// Command stream word
`define CMD_W 32

// Output stream, four RGB565 pixels per beat
`define STREAM_W 64
`define PIXELS_PER_BEAT 4

`endif

/* source/fb_pkg.sv */
`include "fb_consts.svh"

package fb_pkg;

    typedef enum logic [3:0]
    {
        NOP         = 4'd0,
        REG_WRITE   = 4'd1,
        PIXEL_WRITE = 4'd2,
        MEMSET      = 4'd3,
        COMMIT      = 4'd4,
        SWAP        = 4'd5
    } cmd_opcode_e;

    typedef enum logic [3:0]
    {
        SCISSOR_ENABLE = 4'd0,
        SCISSOR_START  = 4'd1,
        SCISSOR_END    = 4'd2,
        CLEAR_COLOR    = 4'd3,
        COLOR_MASK     = 4'd4
    } reg_id_e;

    // Header of a register write
    typedef struct packed
    {
        cmd_opcode_e         opcode;
        reg_id_e             reg_id;
        logic [`CMD_W-9:0]   unused;
    } reg_hdr_t;

    // Header of a pixel write, carries the target position
    typedef struct packed
    {
        cmd_opcode_e              opcode;
        logic [`SCREEN_POS_W-1:0] x;
        logic [`SCREEN_POS_W-1:0] y;
        logic [5:0]               unused;
    } pixel_hdr_t;

    // The opcode sits in the top nibble of both views
    typedef union packed
    {
        reg_hdr_t   reg_hdr;
        pixel_hdr_t pixel_hdr;
    } cmd_word_u;

    typedef struct packed
    {
        logic [`SCREEN_POS_W-1:0] x;
        logic [`SCREEN_POS_W-1:0] y;
    } screen_pos_t;

    typedef struct packed
    {
        logic [`SUB_PIXEL_W-1:0] r;
        logic [`SUB_PIXEL_W-1:0] g;
        logic [`SUB_PIXEL_W-1:0] b;
    } pixel_t;

    // Mask bit 2 enables r, bit 1 g, bit 0 b
    typedef struct packed
    {
        logic        scissor_en;
        screen_pos_t scissor_start;
        screen_pos_t scissor_end;
        pixel_t      clear_color;
        logic [2:0]  mask;
    } fb_conf_t;

    typedef struct packed
    {
        screen_pos_t pos;
        pixel_t      color;
    } pixel_wr_t;

endpackage

/* source/fb_cmd_decoder.sv */
`timescale 1ns/10ps
`include "fb_consts.svh"

module fb_cmd_decoder
(
    input  logic              aclk,
    input  logic              rst,

    input  logic              s_cmd_axis_tvalid,
    output logic              s_cmd_axis_tready,
    input  logic              s_cmd_axis_tlast,
    input  fb_pkg::cmd_word_u s_cmd_axis_tdata,

    input  logic              op_busy,
    input  logic              fb_swapped,
    input  logic              fb_committed,

    output fb_pkg::fb_conf_t  conf,
    output fb_pkg::pixel_wr_t pix_wr,
    output logic              pix_wr_valid,
    output logic              memset_start,
    output logic              commit_start,
    output logic              swap_fb,
    output logic              commit_fb
);
    typedef enum logic [1:0]
    {
        ST_HEADER,
        ST_DATA,
        ST_WAIT_BUSY,
        ST_WAIT_DISPLAY
    } state_e;

    state_e              state_q;
    fb_pkg::cmd_word_u   hdr_q;
    logic [`CMD_W-1:0]   data_w;
    fb_pkg::pixel_t      data_color;
    fb_pkg::screen_pos_t data_pos;
    logic                accept;

    // Commands are framed by their opcode, s_cmd_axis_tlast carries no meaning here
    assign s_cmd_axis_tready = (state_q == ST_HEADER) || (state_q == ST_DATA);
    assign accept = s_cmd_axis_tvalid && s_cmd_axis_tready;

    assign data_w = s_cmd_axis_tdata;
    // RGB888 reduced to six bits per channel
    assign data_color = {data_w[23:18], data_w[15:10], data_w[7:2]};
    assign data_pos = {data_w[10:0], data_w[26:16]};

    always_ff @(posedge aclk)
    begin
        if (accept && (state_q == ST_HEADER))
            hdr_q <= s_cmd_axis_tdata;
        if (accept && (state_q == ST_DATA))
        begin
            pix_wr.pos <= {hdr_q.pixel_hdr.x, hdr_q.pixel_hdr.y};
            pix_wr.color <= data_color;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state_q <= ST_HEADER;
            conf <= '0;
            pix_wr_valid <= 1'b0;
            memset_start <= 1'b0;
            commit_start <= 1'b0;
            swap_fb <= 1'b0;
            commit_fb <= 1'b0;
        end
        else
        begin
            pix_wr_valid <= 1'b0;
            memset_start <= 1'b0;
            commit_start <= 1'b0;
            swap_fb <= 1'b0;
            commit_fb <= 1'b0;

            case (state_q)
                ST_HEADER:
                begin
                    if (accept)
                    begin
                        case (s_cmd_axis_tdata.reg_hdr.opcode)
                            fb_pkg::REG_WRITE, fb_pkg::PIXEL_WRITE:
                                state_q <= ST_DATA;
                            fb_pkg::MEMSET:
                            begin
                                memset_start <= 1'b1;
                                state_q <= ST_WAIT_BUSY;
                            end
                            fb_pkg::COMMIT:
                            begin
                                commit_start <= 1'b1;
                                commit_fb <= 1'b1;
                                state_q <= ST_WAIT_BUSY;
                            end
                            fb_pkg::SWAP:
                            begin
                                swap_fb <= 1'b1;
                                state_q <= ST_WAIT_DISPLAY;
                            end
                            default:
                                state_q <= ST_HEADER;
                        endcase
                    end
                end
                ST_DATA:
                begin
                    if (accept)
                    begin
                        state_q <= ST_HEADER;
                        if (hdr_q.reg_hdr.opcode == fb_pkg::REG_WRITE)
                        begin
                            case (hdr_q.reg_hdr.reg_id)
                                fb_pkg::SCISSOR_ENABLE: conf.scissor_en <= data_w[0];
                                fb_pkg::SCISSOR_START:  conf.scissor_start <= data_pos;
                                fb_pkg::SCISSOR_END:    conf.scissor_end <= data_pos;
                                fb_pkg::CLEAR_COLOR:    conf.clear_color <= data_color;
                                fb_pkg::COLOR_MASK:     conf.mask <= data_w[2:0];
                                default:                conf <= conf;
                            endcase
                        end
                        else
                        begin
                            pix_wr_valid <= 1'b1;
                        end
                    end
                end
                ST_WAIT_BUSY:
                begin
                    // op_busy only rises the cycle after the start strobe
                    if (!op_busy && !memset_start && !commit_start
                        && ((hdr_q.reg_hdr.opcode != fb_pkg::COMMIT) || fb_committed))
                        state_q <= ST_HEADER;
                end
                ST_WAIT_DISPLAY:
                begin
                    if (!swap_fb && fb_swapped)
                        state_q <= ST_HEADER;
                end
                default:
                    state_q <= ST_HEADER;
            endcase
        end
    end

endmodule

/* source/fb_color_buffer.sv */
`timescale 1ns/10ps
`include "fb_consts.svh"

module fb_color_buffer
(
    input  logic              aclk,
    input  logic              rst,

    input  fb_pkg::fb_conf_t  conf,
    input  fb_pkg::pixel_wr_t pix_wr,
    input  logic              pix_wr_valid,
    input  logic              memset_start,
    input  logic              commit_start,
    input  logic              pix_ready,

    output logic              op_busy,
    output fb_pkg::pixel_t    rd_pixel,
    output logic              rd_valid
);
    localparam int X_W = $clog2(`FB_X_RES);
    localparam int Y_W = `FB_ADDR_W - X_W;
    localparam int LAST_IDX = `FB_PIXELS - 1;

    typedef enum logic [1:0]
    {
        OP_IDLE,
        OP_MEMSET,
        OP_COMMIT
    } op_e;

    op_e                      op_q;
    logic [`FB_ADDR_W-1:0]    idx_q;
    fb_pkg::pixel_t           mem [0:`FB_PIXELS-1];

    logic [`SCREEN_POS_W-1:0] sweep_x;
    logic [`SCREEN_POS_W-1:0] sweep_y;
    fb_pkg::screen_pos_t      wr_pos;
    fb_pkg::pixel_t           wr_color;
    logic                     wr_req;
    logic                     in_res;
    logic                     in_scissor;
    logic                     wr_en;
    logic [`FB_ADDR_W-1:0]    wr_addr;
    logic                     rd_issue;

    // Sweep index split into raster coordinates
    assign sweep_x = {{(`SCREEN_POS_W - X_W){1'b0}}, idx_q[X_W-1:0]};
    assign sweep_y = {{(`SCREEN_POS_W - Y_W){1'b0}}, idx_q[`FB_ADDR_W-1:X_W]};

    // A memset step wins, the decoder never overlaps it with pixel writes
    always_comb
    begin
        if (op_q == OP_MEMSET)
        begin
            wr_pos = {sweep_x, sweep_y};
            wr_color = conf.clear_color;
            wr_req = 1'b1;
        end
        else
        begin
            wr_pos = pix_wr.pos;
            wr_color = pix_wr.color;
            wr_req = pix_wr_valid;
        end
    end

    assign in_res = (wr_pos.x < `FB_X_RES) && (wr_pos.y < `FB_Y_RES);
    // Scissor rectangle is inclusive on both ends
    assign in_scissor = !conf.scissor_en
        || ((wr_pos.x >= conf.scissor_start.x) && (wr_pos.x <= conf.scissor_end.x)
            && (wr_pos.y >= conf.scissor_start.y) && (wr_pos.y <= conf.scissor_end.y));
    assign wr_en = wr_req && in_res && in_scissor;
    assign wr_addr = {wr_pos.y[Y_W-1:0], wr_pos.x[X_W-1:0]};

    assign rd_issue = (op_q == OP_COMMIT) && pix_ready;
    assign op_busy = (op_q != OP_IDLE);

    // Per-channel write enables from the color mask
    always_ff @(posedge aclk)
    begin
        if (wr_en && conf.mask[2])
            mem[wr_addr].r <= wr_color.r;
        if (wr_en && conf.mask[1])
            mem[wr_addr].g <= wr_color.g;
        if (wr_en && conf.mask[0])
            mem[wr_addr].b <= wr_color.b;
        if (rd_issue)
            rd_pixel <= mem[idx_q];
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            op_q <= OP_IDLE;
            idx_q <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_issue;
            case (op_q)
                OP_IDLE:
                begin
                    idx_q <= '0;
                    if (memset_start)
                        op_q <= OP_MEMSET;
                    else if (commit_start)
                        op_q <= OP_COMMIT;
                end
                OP_MEMSET:
                begin
                    idx_q <= idx_q + 1'b1;
                    if (idx_q == LAST_IDX)
                        op_q <= OP_IDLE;
                end
                OP_COMMIT:
                begin
                    // Reads advance only while the packer has room
                    if (rd_issue)
                    begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == LAST_IDX)
                            op_q <= OP_IDLE;
                    end
                end
                default:
                    op_q <= OP_IDLE;
            endcase
        end
    end

endmodule

/* source/fb_rgb565_packer.sv */
`timescale 1ns/10ps
`include "fb_consts.svh"

module fb_rgb565_packer
(
    input  logic                 aclk,
    input  logic                 rst,

    input  fb_pkg::pixel_t       rd_pixel,
    input  logic                 rd_valid,
    output logic                 pix_ready,

    output logic                 m_framebuffer_axis_tvalid,
    input  logic                 m_framebuffer_axis_tready,
    output logic                 m_framebuffer_axis_tlast,
    output logic [`STREAM_W-1:0] m_framebuffer_axis_tdata
);
    localparam int BEATS = `FB_PIXELS / `PIXELS_PER_BEAT;
    localparam int SLOT_W = $clog2(`PIXELS_PER_BEAT);
    localparam int PIX_W = `STREAM_W / `PIXELS_PER_BEAT;

    logic [PIX_W-1:0]         rgb565;
    logic [`STREAM_W-1:0]     asm_q;
    logic [SLOT_W:0]          fill_q;
    logic [SLOT_W:0]          fill_base;
    logic [SLOT_W-1:0]        slot;
    logic [$clog2(BEATS)-1:0] beat_q;
    logic                     xfer;

    // 6-6-6 to 5-6-5
    assign rgb565 = {rd_pixel.r[`SUB_PIXEL_W-1:1], rd_pixel.g, rd_pixel.b[`SUB_PIXEL_W-1:1]};

    // A full assembly moves out once the beat register is free or draining
    assign xfer = (fill_q == `PIXELS_PER_BEAT)
        && (!m_framebuffer_axis_tvalid || m_framebuffer_axis_tready);
    assign fill_base = xfer ? '0 : fill_q;
    assign slot = fill_base[SLOT_W-1:0];

    // Room for the pixel in flight and one more read
    assign pix_ready = (fill_base + rd_valid) < `PIXELS_PER_BEAT;

    always_ff @(posedge aclk)
    begin
        if (rd_valid)
            asm_q[slot*PIX_W +: PIX_W] <= rgb565;
        if (xfer)
        begin
            m_framebuffer_axis_tdata <= asm_q;
            m_framebuffer_axis_tlast <= (beat_q == BEATS - 1);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            fill_q <= '0;
            beat_q <= '0;
            m_framebuffer_axis_tvalid <= 1'b0;
        end
        else
        begin
            if (rd_valid)
                fill_q <= fill_base + 1'b1;
            else
                fill_q <= fill_base;

            if (xfer)
            begin
                m_framebuffer_axis_tvalid <= 1'b1;
                // Wraps after the last beat of a commit
                beat_q <= beat_q + 1'b1;
            end
            else if (m_framebuffer_axis_tready)
            begin
                m_framebuffer_axis_tvalid <= 1'b0;
            end
        end
    end

endmodule

/* source/fb_core.sv */
`timescale 1ns/10ps
`include "fb_consts.svh"

module fb_core
(
    input  logic                 aclk,
    input  logic                 rst,

    input  logic                 s_cmd_axis_tvalid,
    output logic                 s_cmd_axis_tready,
    input  logic                 s_cmd_axis_tlast,
    input  logic [`CMD_W-1:0]    s_cmd_axis_tdata,

    // RGB565 stream
    output logic                 m_framebuffer_axis_tvalid,
    input  logic                 m_framebuffer_axis_tready,
    output logic                 m_framebuffer_axis_tlast,
    output logic [`STREAM_W-1:0] m_framebuffer_axis_tdata,

    output logic                 swap_fb,
    input  logic                 fb_swapped,
    output logic                 commit_fb,
    input  logic                 fb_committed
);
    fb_pkg::fb_conf_t  conf;
    fb_pkg::pixel_wr_t pix_wr;
    fb_pkg::pixel_t    rd_pixel;
    logic              pix_wr_valid;
    logic              memset_start;
    logic              commit_start;
    logic              op_busy;
    logic              rd_valid;
    logic              pix_ready;

    fb_cmd_decoder cmd_decoder_i
    (
        .aclk              (aclk),
        .rst               (rst),
        .s_cmd_axis_tvalid (s_cmd_axis_tvalid),
        .s_cmd_axis_tready (s_cmd_axis_tready),
        .s_cmd_axis_tlast  (s_cmd_axis_tlast),
        .s_cmd_axis_tdata  (s_cmd_axis_tdata),
        .op_busy           (op_busy),
        .fb_swapped        (fb_swapped),
        .fb_committed      (fb_committed),
        .conf              (conf),
        .pix_wr            (pix_wr),
        .pix_wr_valid      (pix_wr_valid),
        .memset_start      (memset_start),
        .commit_start      (commit_start),
        .swap_fb           (swap_fb),
        .commit_fb         (commit_fb)
    );

    fb_color_buffer color_buffer_i
    (
        .aclk         (aclk),
        .rst          (rst),
        .conf         (conf),
        .pix_wr       (pix_wr),
        .pix_wr_valid (pix_wr_valid),
        .memset_start (memset_start),
        .commit_start (commit_start),
        .pix_ready    (pix_ready),
        .op_busy      (op_busy),
        .rd_pixel     (rd_pixel),
        .rd_valid     (rd_valid)
    );

    fb_rgb565_packer rgb565_packer_i
    (
        .aclk                      (aclk),
        .rst                       (rst),
        .rd_pixel                  (rd_pixel),
        .rd_valid                  (rd_valid),
        .pix_ready                 (pix_ready),
        .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
        .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
        .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata)
    );

endmodule

/* verification/fb_core_assert.sv */
`timescale 1ns/10ps
`include "fb_consts.svh"

module fb_core_assert
(
    input logic                 aclk,
    input logic                 rst,
    input logic                 m_framebuffer_axis_tvalid,
    input logic                 m_framebuffer_axis_tready,
    input logic [`STREAM_W-1:0] m_framebuffer_axis_tdata,
    input logic                 swap_fb,
    input logic                 commit_fb
);
    // A beat under back-pressure must not change
    stall_hold_a: assert property (@(posedge aclk) disable iff (rst)
        (m_framebuffer_axis_tvalid && !m_framebuffer_axis_tready)
        |=> (m_framebuffer_axis_tvalid && $stable(m_framebuffer_axis_tdata)))
        else $error("output beat changed while stalled");

    swap_pulse_a: assert property (@(posedge aclk) disable iff (rst)
        swap_fb |=> !swap_fb)
        else $error("swap_fb longer than one cycle");

    commit_pulse_a: assert property (@(posedge aclk) disable iff (rst)
        commit_fb |=> !commit_fb)
        else $error("commit_fb longer than one cycle");

    reset_tvalid_a: assert property (@(posedge aclk)
        rst |=> !m_framebuffer_axis_tvalid)
        else $error("tvalid high after reset");

endmodule

bind fb_core fb_core_assert assert_i
(
    .aclk                      (aclk),
    .rst                       (rst),
    .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
    .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
    .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata),
    .swap_fb                   (swap_fb),
    .commit_fb                 (commit_fb)
);

/* verification/fb_core_tb.sv */
`timescale 1ns/10ps
`include "fb_consts.svh"

module fb_core_tb;

    localparam int BEATS = `FB_PIXELS / `PIXELS_PER_BEAT;
    // Six tests of up to about 1500 cycles each, with twice the margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                 aclk;
    logic                 rst;
    logic                 cmd_valid;
    logic                 cmd_ready;
    logic                 cmd_last;
    logic [`CMD_W-1:0]    cmd_data;
    logic                 out_valid;
    logic                 out_ready;
    logic                 out_last;
    logic [`STREAM_W-1:0] out_data;
    logic                 swap_fb;
    logic                 fb_swapped;
    logic                 commit_fb;
    logic                 fb_committed;

    integer               seed;
    int                   cycles;
    int                   checks;
    int                   errors;
    int                   tests_run;

    // Reference image and the register state it is drawn with
    fb_pkg::pixel_t       model [0:`FB_PIXELS-1];
    fb_pkg::fb_conf_t     model_conf;

    fb_core dut_i
    (
        .aclk                      (aclk),
        .rst                       (rst),
        .s_cmd_axis_tvalid         (cmd_valid),
        .s_cmd_axis_tready         (cmd_ready),
        .s_cmd_axis_tlast          (cmd_last),
        .s_cmd_axis_tdata          (cmd_data),
        .m_framebuffer_axis_tvalid (out_valid),
        .m_framebuffer_axis_tready (out_ready),
        .m_framebuffer_axis_tlast  (out_last),
        .m_framebuffer_axis_tdata  (out_data),
        .swap_fb                   (swap_fb),
        .fb_swapped                (fb_swapped),
        .commit_fb                 (commit_fb),
        .fb_committed              (fb_committed)
    );

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic compare_beat(input string name, input logic [`STREAM_W-1:0] exp,
                                input logic [`STREAM_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR t=%0t %s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - errs_before);
    endtask

    function automatic logic [`CMD_W-1:0] op_header(input fb_pkg::cmd_opcode_e op);
        fb_pkg::cmd_word_u w;
        w = '0;
        w.reg_hdr.opcode = op;
        return w;
    endfunction

    function automatic logic [`CMD_W-1:0] reg_header(input fb_pkg::reg_id_e id);
        fb_pkg::cmd_word_u w;
        w = '0;
        w.reg_hdr.opcode = fb_pkg::REG_WRITE;
        w.reg_hdr.reg_id = id;
        return w;
    endfunction

    function automatic logic [`CMD_W-1:0] pixel_header(input int x, input int y);
        fb_pkg::cmd_word_u w;
        w = '0;
        w.pixel_hdr.opcode = fb_pkg::PIXEL_WRITE;
        w.pixel_hdr.x = 11'(x);
        w.pixel_hdr.y = 11'(y);
        return w;
    endfunction

    function automatic logic [`CMD_W-1:0] pos_word(input int x, input int y);
        return {5'b0, 11'(y), 5'b0, 11'(x)};
    endfunction

    // RGB888 keeps the top six bits of each channel
    function automatic fb_pkg::pixel_t reduce_rgb(input logic [23:0] rgb);
        return {rgb[23:18], rgb[15:10], rgb[7:2]};
    endfunction

    function automatic void model_write(input int x, input int y, input fb_pkg::pixel_t c);
        int idx;
        bit in_scissor;
        in_scissor = !model_conf.scissor_en
            || (x >= int'(model_conf.scissor_start.x) && x <= int'(model_conf.scissor_end.x)
                && y >= int'(model_conf.scissor_start.y)
                && y <= int'(model_conf.scissor_end.y));
        if (x < `FB_X_RES && y < `FB_Y_RES && in_scissor)
        begin
            idx = y * `FB_X_RES + x;
            if (model_conf.mask[2])
                model[idx].r = c.r;
            if (model_conf.mask[1])
                model[idx].g = c.g;
            if (model_conf.mask[0])
                model[idx].b = c.b;
        end
    endfunction

    // Pixel k of the beat in bits 16k+15:16k, RGB565 from the top bits
    function automatic logic [`STREAM_W-1:0] expected_beat(input int k);
        logic [`STREAM_W-1:0] beat;
        fb_pkg::pixel_t p;
        beat = '0;
        for (int i = 0; i < `PIXELS_PER_BEAT; i++)
        begin
            p = model[k * `PIXELS_PER_BEAT + i];
            beat[16*i +: 16] = {p.r[5:1], p.g, p.b[5:1]};
        end
        return beat;
    endfunction

    task automatic send_word(input logic [`CMD_W-1:0] w);
        @(negedge aclk);
        cmd_valid = 1'b1;
        cmd_data = w;
        while (!cmd_ready)
            @(negedge aclk);
        // Word transfers on the next rising edge
        @(negedge aclk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_cmd_ready();
        while (!cmd_ready)
            @(negedge aclk);
    endtask

    task automatic write_reg(input fb_pkg::reg_id_e id, input logic [`CMD_W-1:0] data);
        send_word(reg_header(id));
        send_word(data);
        case (id)
            fb_pkg::SCISSOR_ENABLE: model_conf.scissor_en = data[0];
            fb_pkg::SCISSOR_START:  model_conf.scissor_start = {data[10:0], data[26:16]};
            fb_pkg::SCISSOR_END:    model_conf.scissor_end = {data[10:0], data[26:16]};
            fb_pkg::CLEAR_COLOR:    model_conf.clear_color = reduce_rgb(data[23:0]);
            fb_pkg::COLOR_MASK:     model_conf.mask = data[2:0];
            default:                model_conf = model_conf;
        endcase
    endtask

    task automatic write_pixel(input int x, input int y, input logic [23:0] rgb);
        send_word(pixel_header(x, y));
        send_word({8'h00, rgb});
        model_write(x, y, reduce_rgb(rgb));
    endtask

    task automatic run_memset();
        send_word(op_header(fb_pkg::MEMSET));
        compare_bit("s_cmd_axis_tready", 1'b0, cmd_ready);
        wait_cmd_ready();
        for (int idx = 0; idx < `FB_PIXELS; idx++)
            model_write(idx % `FB_X_RES, idx / `FB_X_RES, model_conf.clear_color);
    endtask

    // Collects one frame, the command side must stay stalled until fb_committed
    task automatic run_commit(input bit gaps);
        int beat;
        send_word(op_header(fb_pkg::COMMIT));
        compare_bit("commit_fb", 1'b1, commit_fb);
        beat = 0;
        while (beat < BEATS)
        begin
            @(negedge aclk);
            compare_bit("s_cmd_axis_tready", 1'b0, cmd_ready);
            out_ready = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            if (out_valid && out_ready)
            begin
                compare_beat("m_framebuffer_axis_tdata", expected_beat(beat), out_data);
                compare_bit("m_framebuffer_axis_tlast", beat == BEATS - 1, out_last);
                beat++;
            end
        end
        @(negedge aclk);
        out_ready = 1'b1;
        compare_bit("s_cmd_axis_tready", 1'b0, cmd_ready);
        fb_committed = 1'b1;
        wait_cmd_ready();
        fb_committed = 1'b0;
    endtask

    task automatic test_reset_state();
        int errs_before;
        errs_before = errors;
        compare_bit("m_framebuffer_axis_tvalid", 1'b0, out_valid);
        compare_bit("swap_fb", 1'b0, swap_fb);
        compare_bit("commit_fb", 1'b0, commit_fb);
        compare_bit("s_cmd_axis_tready", 1'b1, cmd_ready);
        // Memory has no reset, so clear it to black first
        write_reg(fb_pkg::COLOR_MASK, 32'h7);
        write_reg(fb_pkg::CLEAR_COLOR, 32'h0);
        run_memset();
        run_commit(1'b0);
        finish_test("test_reset_state", errs_before);
    endtask

    task automatic test_pixel_writes();
        int errs_before;
        int x;
        int y;
        errs_before = errors;
        for (int n = 0; n < 40; n++)
        begin
            x = ($random(seed) & 32'h7fff_ffff) % 20;
            y = ($random(seed) & 32'h7fff_ffff) % 11;
            write_pixel(x, y, 24'($random(seed)));
        end
        write_pixel(2000, 3, 24'hffffff);
        write_pixel(5, 1500, 24'hffffff);
        run_commit(1'b0);
        finish_test("test_pixel_writes", errs_before);
    endtask

    task automatic test_scissor_memset();
        int errs_before;
        errs_before = errors;
        write_reg(fb_pkg::CLEAR_COLOR, 32'($random(seed)) & 32'h00ff_ffff);
        write_reg(fb_pkg::SCISSOR_START, pos_word(3, 2));
        write_reg(fb_pkg::SCISSOR_END, pos_word(10, 5));
        write_reg(fb_pkg::SCISSOR_ENABLE, 32'h1);
        run_memset();
        write_reg(fb_pkg::SCISSOR_ENABLE, 32'h0);
        run_commit(1'b0);
        finish_test("test_scissor_memset", errs_before);
    endtask

    task automatic test_green_mask();
        int errs_before;
        errs_before = errors;
        write_reg(fb_pkg::COLOR_MASK, 32'h2);
        for (int n = 0; n < 10; n++)
            write_pixel(n, n % `FB_Y_RES, 24'($random(seed)));
        write_reg(fb_pkg::CLEAR_COLOR, 32'h00a5_5a3c);
        run_memset();
        write_reg(fb_pkg::COLOR_MASK, 32'h7);
        run_commit(1'b0);
        finish_test("test_green_mask", errs_before);
    endtask

    task automatic test_commit_backpressure();
        int errs_before;
        errs_before = errors;
        for (int n = 0; n < 8; n++)
            write_pixel(15 - n, 7 - (n % 4), 24'($random(seed)));
        run_commit(1'b1);
        finish_test("test_commit_backpressure", errs_before);
    endtask

    task automatic test_swap();
        int errs_before;
        errs_before = errors;
        send_word(op_header(fb_pkg::SWAP));
        compare_bit("swap_fb", 1'b1, swap_fb);
        repeat (8)
        begin
            @(negedge aclk);
            compare_bit("s_cmd_axis_tready", 1'b0, cmd_ready);
            compare_bit("swap_fb", 1'b0, swap_fb);
        end
        fb_swapped = 1'b1;
        wait_cmd_ready();
        fb_swapped = 1'b0;
        // Commands flow again after the acknowledgement
        write_pixel(1, 1, 24'h12_34_56);
        run_commit(1'b0);
        finish_test("test_swap", errs_before);
    endtask

    initial
    begin
        seed = 32'h28c8_395b;
        cycles = 0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_last = 1'b0;
        cmd_data = '0;
        out_ready = 1'b1;
        fb_swapped = 1'b0;
        fb_committed = 1'b0;
        model_conf = '0;
        for (int i = 0; i < `FB_PIXELS; i++)
            model[i] = '0;

        repeat (4)
            @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;

        test_reset_state();
        test_pixel_writes();
        test_scissor_memset();
        test_green_mask();
        test_commit_backpressure();
        test_swap();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/fb_pkg.sv
source/fb_cmd_decoder.sv
source/fb_color_buffer.sv
source/fb_rgb565_packer.sv
source/fb_core.sv
verification/fb_core_assert.sv
verification/fb_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the framebuffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fb_core_tb -Mdir obj_dir -o fb_core_sim \
    -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1
